//--- hw/front_macros.svh
// Front end constants
`ifndef FRONT_MACROS_SVH
`define FRONT_MACROS_SVH

// Event vectors, low byte address of each pair
`define FRONT_VEC_NMI 16'hFFFA
`define FRONT_VEC_RES 16'hFFFC
`define FRONT_VEC_IRQ 16'hFFFE

// Opcode forced into the instruction register on an event
`define FRONT_BRK_OPCODE 8'h00

// Flops per event line synchronizer, two or more
`define FRONT_SYNC_STAGES 2

`endif

//--- hw/frontPkg.sv
// Front end shared types
`default_nettype none

package frontPkg;

    // Event that won arbitration
    typedef enum logic [2:0] {
        intNone,
        intRes,
        intNmi,
        intIrq
    } intKind;

    // Coarse instruction class from predecode
    typedef enum logic [2:0] {
        clsAlu,     // cc = 01
        clsRmw,     // cc = 10
        clsMisc,    // cc = 00
        clsBranch,  // xxy10000
        clsControl, // BRK, JSR, RTI, RTS
        clsIllegal  // cc = 11
    } instrClass;

    // Fetch control states
    typedef enum logic [1:0] {
        stDecide,
        stFetch,
        stExec
    } frontState;

    // Usual 6502 aaa-bbb-cc split
    typedef struct packed {
        logic [2:0] aaa;
        logic [2:0] bbb;
        logic [1:0] cc;
    } opGroup;

    // Branch layout, flag select and wanted value
    typedef struct packed {
        logic [1:0] flagSel;
        logic       cond;
        logic [4:0] low5;
    } opBranch;

    // One opcode byte, two decodings
    typedef union packed {
        opGroup  grp;
        opBranch br;
    } opFields;

endpackage

`default_nettype wire

//--- hw/interruptArbiter.sv
// Event line arbiter
`timescale 1ns/100ps
`default_nettype none

`include "front_macros.svh"

module interruptArbiter (
    input  wire logic             rstAll,
    input  wire logic             irqHandled,
    input  wire logic             nmiN,
    input  wire logic             irqN,
    input  wire logic             resN,
    input  wire logic             iMask,
    input  wire logic             intAck,
    input  wire frontPkg::intKind ackKind,
    output logic                  intReq,
    output frontPkg::intKind      reqKind
);

    logic [`FRONT_SYNC_STAGES-1:0] nmiSync; // Shift toward the MSB
    logic [`FRONT_SYNC_STAGES-1:0] irqSync;
    logic [`FRONT_SYNC_STAGES-1:0] resSync;

    logic nmiLine;   // Synchronized levels, active low
    logic irqLine;
    logic resLine;

    logic nmiPrev;   // Last synchronized NMI level
    logic nmiFall;
    logic nmiPend;
    logic resPend;
    logic irqActive;

    // Lines idle high, so the chains reset to ones
    always_ff @(posedge rstAll or posedge irqHandled) begin
        if (irqHandled) begin
            nmiSync <= '1;
            irqSync <= '1;
            resSync <= '1;
        end else begin
            nmiSync <= {nmiSync[`FRONT_SYNC_STAGES-2:0], nmiN};
            irqSync <= {irqSync[`FRONT_SYNC_STAGES-2:0], irqN};
            resSync <= {resSync[`FRONT_SYNC_STAGES-2:0], resN};
        end
    end

    assign nmiLine = nmiSync[`FRONT_SYNC_STAGES-1];
    assign irqLine = irqSync[`FRONT_SYNC_STAGES-1];
    assign resLine = resSync[`FRONT_SYNC_STAGES-1];

    assign nmiFall = nmiPrev & ~nmiLine; // High to low only

    always_ff @(posedge rstAll or posedge irqHandled) begin
        if (irqHandled) begin
            nmiPrev <= 1'b1;
            nmiPend <= 1'b0;
            resPend <= 1'b0;
        end else begin
            nmiPrev <= nmiLine;

            // A fresh edge wins over an acknowledge in the same cycle
            if (nmiFall) begin
                nmiPend <= 1'b1;
            end else if (intAck && ackKind == frontPkg::intNmi) begin
                nmiPend <= 1'b0;
            end

            // RES holds while the line is low
            if (!resLine) begin
                resPend <= 1'b1;
            end else if (intAck && ackKind == frontPkg::intRes) begin
                resPend <= 1'b0;
            end
        end
    end

    assign irqActive = ~irqLine & ~iMask; // Level sensitive, masked by I flag

    // Fixed priority RES > NMI > IRQ
    always_comb begin
        if (resPend) begin
            reqKind = frontPkg::intRes;
        end else if (nmiPend) begin
            reqKind = frontPkg::intNmi;
        end else if (irqActive) begin
            reqKind = frontPkg::intIrq;
        end else begin
            reqKind = frontPkg::intNone;
        end
    end

    assign intReq = resPend | nmiPend | irqActive;

endmodule

`default_nettype wire

//--- hw/opcodePredecode.sv
// Opcode register and predecode
`timescale 1ns/100ps
`default_nettype none

`include "front_macros.svh"

module opcodePredecode (
    input  wire logic           rstAll,
    input  wire logic           irqHandled,
    input  wire logic           loadOp,
    input  wire logic           forceBrk,
    input  wire logic [7:0]     dataIn,
    output logic                opValid,
    output logic [7:0]          opcode,
    output frontPkg::instrClass opClass,
    output logic [1:0]          opLength,
    output logic [1:0]          branchFlag,
    output logic                branchCond
);

    frontPkg::opFields opReg; // Instruction register
    logic isControl;
    logic isBranch;

    always_ff @(posedge rstAll or posedge irqHandled) begin
        if (irqHandled) begin
            opValid <= 1'b0;
        end else begin
            opValid <= loadOp; // One cycle after the load
        end
    end

    // Event injection replaces the bus byte with BRK
    always_ff @(posedge rstAll) begin
        if (loadOp) begin
            opReg <= forceBrk ? `FRONT_BRK_OPCODE : dataIn;
        end
    end

    assign opcode = opReg;

    // 00, 20, 40, 60
    assign isControl = ~opReg.grp.aaa[2] & (opReg.grp.bbb == 3'b000) & (opReg.grp.cc == 2'b00);
    assign isBranch  = opReg.br.low5 == 5'b10000;

    always_comb begin
        if (isBranch) begin
            opClass = frontPkg::clsBranch;
        end else if (isControl) begin
            opClass = frontPkg::clsControl;
        end else begin
            case (opReg.grp.cc)
                2'b01:   opClass = frontPkg::clsAlu;
                2'b10:   opClass = frontPkg::clsRmw;
                2'b00:   opClass = frontPkg::clsMisc;
                default: opClass = frontPkg::clsIllegal;
            endcase
        end
    end

    // First match wins
    always_comb begin
        if (isControl) begin
            opLength = 2'd1;
        end else if (isBranch) begin
            opLength = 2'd2;
        end else if (opReg.grp.bbb == 3'b011 || opReg.grp.bbb == 3'b111 ||
                     (opReg.grp.cc == 2'b01 && opReg.grp.bbb == 3'b110)) begin
            opLength = 2'd3; // Absolute forms
        end else if (opReg.grp.cc != 2'b01 &&
                     (opReg.grp.bbb == 3'b010 || opReg.grp.bbb == 3'b110)) begin
            opLength = 2'd1; // Implied and accumulator
        end else begin
            opLength = 2'd2;
        end
    end

    assign branchFlag = opReg.br.flagSel; // N, V, C, Z
    assign branchCond = opReg.br.cond;

endmodule

`default_nettype wire

//--- hw/frontCtrl.sv
// Fetch and event injection control
`timescale 1ns/100ps
`default_nettype none

`include "front_macros.svh"

module frontCtrl (
    input  wire logic             rstAll,
    input  wire logic             irqHandled,
    input  wire logic             dataValid,
    input  wire logic [7:0]       dataIn,
    input  wire logic             rdy,
    input  wire logic             busWrite,
    input  wire logic             instrDone,
    input  wire logic             intReq,
    input  wire frontPkg::intKind reqKind,
    output logic                  fetchReq,
    output logic                  stall,
    output logic                  loadOp,
    output logic                  forceBrk,
    output logic                  intAck,
    output frontPkg::intKind      ackKind,
    output frontPkg::intKind      eventKind,
    output logic [15:0]           vectorAddr,
    output logic                  vectorValid
);

    frontPkg::frontState state;
    logic injLoad;  // Load of a forced BRK, one cycle
    logic fetchHit; // Opcode byte accepted this cycle

    // Reads wait on RDY, writes always proceed
    assign stall = ~rdy & ~busWrite;

    assign fetchHit = (state == frontPkg::stFetch) & dataValid & ~stall;

    assign loadOp   = fetchHit | injLoad;
    assign forceBrk = injLoad;
    assign intAck   = injLoad; // Acknowledge rides on the injection

    always_ff @(posedge rstAll or posedge irqHandled) begin
        if (irqHandled) begin
            state    <= frontPkg::stDecide;
            injLoad  <= 1'b0;
            fetchReq <= 1'b0;
            ackKind  <= frontPkg::intNone;
        end else begin
            injLoad  <= 1'b0;
            fetchReq <= 1'b0;
            case (state)
                frontPkg::stDecide: begin
                    if (intReq) begin
                        injLoad <= 1'b1;
                        ackKind <= reqKind; // Kind held for the vector
                        state   <= frontPkg::stExec;
                    end else begin
                        fetchReq <= 1'b1;
                        state    <= frontPkg::stFetch;
                    end
                end
                frontPkg::stFetch: begin
                    if (fetchHit) begin
                        state <= frontPkg::stExec;
                    end
                end
                frontPkg::stExec: begin
                    if (instrDone) begin
                        state <= frontPkg::stDecide; // Decide on next cycle
                    end
                end
                default: state <= frontPkg::stDecide;
            endcase
        end
    end

    // Updated on every load so it lines up with opValid
    always_ff @(posedge rstAll or posedge irqHandled) begin
        if (irqHandled) begin
            vectorValid <= 1'b0;
            vectorAddr  <= 16'h0000;
            eventKind   <= frontPkg::intNone;
        end else if (loadOp) begin
            if (injLoad) begin
                vectorValid <= 1'b1;
                eventKind   <= ackKind;
                case (ackKind)
                    frontPkg::intRes: vectorAddr <= `FRONT_VEC_RES;
                    frontPkg::intNmi: vectorAddr <= `FRONT_VEC_NMI;
                    default:          vectorAddr <= `FRONT_VEC_IRQ;
                endcase
            end else begin
                // Software BRK shares the IRQ vector
                vectorValid <= dataIn == `FRONT_BRK_OPCODE;
                vectorAddr  <= `FRONT_VEC_IRQ;
                eventKind   <= frontPkg::intNone;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/cpuFrontEnd.sv
// CPU front end top level
`timescale 1ns/100ps
`default_nettype none

module cpuFrontEnd (
    input  wire logic           rstAll,
    input  wire logic           irqHandled,
    input  wire logic           nmiN,
    input  wire logic           irqN,
    input  wire logic           resN,
    input  wire logic [7:0]     dataIn,
    input  wire logic           dataValid,
    input  wire logic           rdy,
    input  wire logic           busWrite,
    input  wire logic           instrDone,
    input  wire logic           iMask,
    output logic                fetchReq,
    output logic                stall,
    output logic                opValid,
    output logic [7:0]          opcode,
    output frontPkg::instrClass opClass,
    output logic [1:0]          opLength,
    output logic [1:0]          branchFlag,
    output logic                branchCond,
    output logic [15:0]         vectorAddr,
    output logic                vectorValid,
    output frontPkg::intKind    eventKind
);

    logic             intReq;
    frontPkg::intKind reqKind;
    logic             intAck;
    frontPkg::intKind ackKind;
    logic             loadOp;
    logic             forceBrk;

    interruptArbiter arbiter_i (
        .rstAll     (rstAll),
        .irqHandled (irqHandled),
        .nmiN       (nmiN),
        .irqN       (irqN),
        .resN       (resN),
        .iMask      (iMask),
        .intAck     (intAck),
        .ackKind    (ackKind),
        .intReq     (intReq),
        .reqKind    (reqKind)
    );

    opcodePredecode predecode_i (
        .rstAll     (rstAll),
        .irqHandled (irqHandled),
        .loadOp     (loadOp),
        .forceBrk   (forceBrk),
        .dataIn     (dataIn),
        .opValid    (opValid),
        .opcode     (opcode),
        .opClass    (opClass),
        .opLength   (opLength),
        .branchFlag (branchFlag),
        .branchCond (branchCond)
    );

    frontCtrl ctrl_i (
        .rstAll      (rstAll),
        .irqHandled  (irqHandled),
        .dataValid   (dataValid),
        .dataIn      (dataIn),      // Spots a software BRK
        .rdy         (rdy),
        .busWrite    (busWrite),
        .instrDone   (instrDone),
        .intReq      (intReq),
        .reqKind     (reqKind),
        .fetchReq    (fetchReq),
        .stall       (stall),
        .loadOp      (loadOp),
        .forceBrk    (forceBrk),
        .intAck      (intAck),
        .ackKind     (ackKind),
        .eventKind   (eventKind),
        .vectorAddr  (vectorAddr),
        .vectorValid (vectorValid)
    );

endmodule

`default_nettype wire

//--- verif/cpuFrontEnd_assertions.sv
// Front end protocol checks
`timescale 1ns/100ps
`default_nettype none

module cpuFrontEnd_assertions (
    input wire logic                rstAll,
    input wire logic                irqHandled,
    input wire logic                fetchReq,
    input wire logic                loadOp,
    input wire logic                opValid,
    input wire logic                stall,
    input wire logic                intAck,
    input wire logic                forceBrk,
    input wire frontPkg::intKind    ackKind,
    input wire logic                vectorValid,
    input wire frontPkg::frontState state
);

    int failCount = 0; // Failed assertions so far

    opAfterLoad: assert property (@(posedge rstAll) disable iff (irqHandled)
        loadOp |=> opValid)
        else begin
            $error("opValid missing one cycle after loadOp");
            failCount++;
        end

    opOnlyAfterLoad: assert property (@(posedge rstAll) disable iff (irqHandled)
        opValid |-> $past(loadOp))
        else begin
            $error("opValid without a load the cycle before");
            failCount++;
        end

    // A stalled read must not capture the bus byte
    noLoadInStall: assert property (@(posedge rstAll) disable iff (irqHandled)
        (state == frontPkg::stFetch && stall) |-> !loadOp)
        else begin
            $error("opcode captured during a stall");
            failCount++;
        end

    quietInReset: assert property (@(posedge rstAll)
        irqHandled |-> !fetchReq && !opValid && !intAck && !loadOp && !vectorValid &&
                       state == frontPkg::stDecide)
        else begin
            $error("control output active during reset");
            failCount++;
        end

    // Acknowledge names a real event from the arbiter
    ackWithBrk: assert property (@(posedge rstAll) disable iff (irqHandled)
        intAck |-> forceBrk && ackKind != frontPkg::intNone)
        else begin
            $error("intAck without forceBrk or without an event kind");
            failCount++;
        end

    // Single request issued from the decision state
    fetchPerDecision: assert property (@(posedge rstAll) disable iff (irqHandled)
        fetchReq |-> ($past(state) == frontPkg::stDecide) ##1 !fetchReq)
        else begin
            $error("fetchReq outside a single decision");
            failCount++;
        end

endmodule

bind cpuFrontEnd cpuFrontEnd_assertions chk_i (
    .rstAll      (rstAll),
    .irqHandled  (irqHandled),
    .fetchReq    (fetchReq),
    .loadOp      (loadOp),
    .opValid     (opValid),
    .stall       (stall),
    .intAck      (intAck),
    .forceBrk    (forceBrk),
    .ackKind     (ackKind),
    .vectorValid (vectorValid),
    .state       (ctrl_i.state)
);

`default_nettype wire

//--- verif/tbCpuFrontEnd.sv
// CPU front end testbench
`timescale 1ns/100ps
`default_nettype none

`include "front_macros.svh"

module tbCpuFrontEnd;

    localparam int opsTotal      = 64;
    localparam int instrWorst    = 14 + `FRONT_SYNC_STAGES; // Fetch, exec and sync delay
    localparam int timeoutCycles = 2 * (16 + 40 + opsTotal * instrWorst);

    logic rstAll, irqHandled, nmiN, irqN, resN, dataValid, rdy, busWrite, instrDone, iMask;
    logic [7:0] dataIn;
    logic fetchReq, stall, opValid, branchCond, vectorValid;
    logic [7:0] opcode;
    logic [1:0] opLength, branchFlag;
    logic [15:0] vectorAddr;
    frontPkg::instrClass opClass;
    frontPkg::intKind eventKind;

    int seed = 32'hb41d321f;
    int errCount = 0, failMark = 0, testNum = 0, passCount = 0, cycleCount = 0;
    int opCount = 0, fetchCount = 0, injCount = 0, softBrkCount = 0;
    int respDelay = -1, coreDelay = -1;
    logic fetchTaken = 1'b0, brkNext = 1'b0, irqMode = 1'b0;
    logic [7:0] takenByte;
    frontPkg::intKind kindQ[$]; // Expected injections in order

    cpuFrontEnd dut_i (.*);

    always #50 rstAll = ~rstAll;

    function automatic int randRange(input int lo, input int hi);
        return lo + ($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    function automatic frontPkg::instrClass modelClass(input logic [7:0] b);
        frontPkg::opFields f;
        f = b;
        if (f.br.low5 == 5'b10000) return frontPkg::clsBranch;
        if (b inside {8'h00, 8'h20, 8'h40, 8'h60}) return frontPkg::clsControl;
        case (f.grp.cc)
            2'b01:   return frontPkg::clsAlu;
            2'b10:   return frontPkg::clsRmw;
            2'b00:   return frontPkg::clsMisc;
            default: return frontPkg::clsIllegal;
        endcase
    endfunction

    function automatic logic [1:0] modelLength(input logic [7:0] b);
        frontPkg::opFields f;
        f = b;
        if (b inside {8'h00, 8'h20, 8'h40, 8'h60}) return 2'd1;
        if (f.br.low5 == 5'b10000) return 2'd2;
        if (f.grp.bbb inside {3'b011, 3'b111} || (f.grp.cc == 2'b01 && f.grp.bbb == 3'b110))
            return 2'd3;
        if (f.grp.cc != 2'b01 && f.grp.bbb inside {3'b010, 3'b110}) return 2'd1;
        return 2'd2;
    endfunction

    function automatic logic [15:0] vectorFor(input frontPkg::intKind kind);
        case (kind)
            frontPkg::intRes: return `FRONT_VEC_RES;
            frontPkg::intNmi: return `FRONT_VEC_NMI;
            default:          return `FRONT_VEC_IRQ;
        endcase
    endfunction

    task automatic valueError(input string what, input int got, input int exp);
        $display("error %0t: %s is %0h, expected %0h", $time, what, got, exp);
        errCount++;
    endtask

    task automatic checkFetch(input logic [7:0] b);
        logic isBrk;
        isBrk = (b == `FRONT_BRK_OPCODE);
        fetchCount++;
        if (isBrk) softBrkCount++;
        assert (opcode == b) else valueError("opcode", opcode, b);
        assert (opClass == modelClass(b)) else valueError("class", opClass, modelClass(b));
        assert (opLength == modelLength(b)) else valueError("length", opLength, modelLength(b));
        assert (branchFlag == b[7:6] && branchCond == b[5]) // Flag select and wanted value
            else valueError("branch fields", {branchFlag, branchCond}, b[7:5]);
        assert (eventKind == frontPkg::intNone) else valueError("eventKind", eventKind, 0);
        assert (vectorValid == isBrk && (!isBrk || vectorAddr == `FRONT_VEC_IRQ))
            else valueError("software BRK vector", vectorAddr, `FRONT_VEC_IRQ);
    endtask

    task automatic checkInject();
        frontPkg::intKind exp;
        injCount++;
        if (kindQ.size() != 0) begin
            exp = kindQ.pop_front();
        end else if (irqMode) begin
            exp = frontPkg::intIrq; // Repeats while irqN is held low
        end else begin
            $display("unexpected event injection at time %0t", $time);
            errCount++;
            return;
        end
        assert (opcode == `FRONT_BRK_OPCODE) else valueError("forced opcode", opcode, 0);
        assert (eventKind == exp) else valueError("eventKind", eventKind, exp);
        assert (vectorValid && vectorAddr == vectorFor(exp))
            else valueError("event vector", vectorAddr, vectorFor(exp));
    endtask

    task automatic waitMore(ref int counter, input int n);
        int target;
        target = counter + n;
        while (counter < target) @(posedge rstAll);
    endtask

    task automatic endTest(input string name);
        int fails;
        fails = errCount + dut_i.chk_i.failCount;
        testNum++;
        if (fails == failMark) begin
            $display("test %0d %s: ok", testNum, name);
            passCount++;
        end else begin
            $display("test %0d %s: %0d errors", testNum, name, fails - failMark);
        end
        failMark = fails;
    endtask

    // Bus responder holds dataValid until a cycle without stall
    always @(posedge rstAll) begin
        fetchTaken <= 1'b0;
        if (dataValid && (rdy || busWrite)) begin
            dataValid  <= 1'b0;
            fetchTaken <= 1'b1;
            takenByte  <= dataIn;
        end else if (respDelay == 0) begin
            dataValid <= 1'b1;
            dataIn    <= brkNext ? `FRONT_BRK_OPCODE : 8'($random(seed));
            respDelay <= -1;
        end else if (respDelay > 0) begin
            respDelay <= respDelay - 1;
        end
        if (fetchReq) respDelay <= randRange(0, 3);
    end

    // Core model pulses instrDone 1 to 4 cycles after opValid
    always @(posedge rstAll) begin
        instrDone <= 1'b0;
        if (opValid) begin
            coreDelay <= randRange(0, 3);
        end else if (coreDelay == 0) begin
            instrDone <= 1'b1;
            coreDelay <= -1;
        end else if (coreDelay > 0) begin
            coreDelay <= coreDelay - 1;
        end
    end

    always @(posedge rstAll) begin
        assert (stall == (!rdy && !busWrite)) else valueError("stall", stall, !rdy && !busWrite);
        if (opValid) begin
            opCount++;
            if (fetchTaken) checkFetch(takenByte);
            else checkInject();
        end
    end

    always @(posedge rstAll) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("timeout: run did not finish within %0d cycles", timeoutCycles);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        int totalFails;
        rstAll     = 1'b0;
        irqHandled <= 1'b1;
        nmiN       = 1'b1;
        irqN       = 1'b1;
        resN       = 1'b1;
        iMask      = 1'b0;
        dataIn     = 8'h00;
        dataValid  = 1'b0;
        rdy        = 1'b1;
        busWrite   = 1'b0;
        instrDone  = 1'b0;
        repeat (16) @(posedge rstAll);
        irqHandled <= 1'b0;
        waitMore(opCount, 30);
        endTest("random opcodes");
        repeat (40) begin
            @(posedge rstAll);
            rdy      <= (randRange(0, 1) == 1);
            busWrite <= (randRange(0, 3) == 0); // Write cycles ignore rdy
        end
        @(posedge rstAll);
        rdy      <= 1'b1;
        busWrite <= 1'b0;
        waitMore(opCount, 2);
        endTest("rdy stall");
        kindQ.push_back(frontPkg::intNmi);
        nmiN <= 1'b0;
        while (kindQ.size() != 0) @(posedge rstAll);
        waitMore(opCount, 4); // Second service would show as unexpected
        nmiN <= 1'b1;
        endTest("nmi edge");
        irqMode <= 1'b1;
        irqN    <= 1'b0;
        waitMore(injCount, 3);
        irqN <= 1'b1;
        waitMore(fetchCount, 1);
        irqMode <= 1'b0;
        iMask   <= 1'b1;
        irqN    <= 1'b0;
        waitMore(opCount, 6);
        irqN <= 1'b1;
        repeat (`FRONT_SYNC_STAGES + 1) @(posedge rstAll);
        iMask <= 1'b0;
        endTest("irq level and mask");
        kindQ.push_back(frontPkg::intRes);
        kindQ.push_back(frontPkg::intNmi);
        iMask <= 1'b1;
        resN  <= 1'b0;
        nmiN  <= 1'b0;
        irqN  <= 1'b0;
        @(posedge rstAll);
        resN <= 1'b1;
        while (kindQ.size() != 0) @(posedge rstAll);
        waitMore(opCount, 3);
        nmiN <= 1'b1;
        irqN <= 1'b1;
        repeat (`FRONT_SYNC_STAGES + 1) @(posedge rstAll);
        iMask <= 1'b0;
        endTest("reset priority");
        brkNext <= 1'b1;
        waitMore(softBrkCount, 1);
        brkNext <= 1'b0;
        waitMore(opCount, 2);
        endTest("software brk");
        totalFails = errCount + dut_i.chk_i.failCount;
        $display("%0d tests, %0d passed, %0d errors", testNum, passCount, totalFails);
        if (totalFails == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+hw
hw/frontPkg.sv
hw/interruptArbiter.sv
hw/opcodePredecode.sv
hw/frontCtrl.sv
hw/cpuFrontEnd.sv
verif/cpuFrontEnd_assertions.sv
verif/tbCpuFrontEnd.sv
